// ==== src/mbu_pkg.sv ====
package mbu_pkg;

	//////////////////////////////////////////////////
	// widths and lane count
	//////////////////////////////////////////////////
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = data_w / 8;
	localparam int num_lanes_default = 2;
	localparam int id_w = (num_lanes_default > 1) ? $clog2(num_lanes_default) : 1;

	typedef enum logic {op_load, op_store} mem_op_e;

	typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

	typedef enum logic [1:0] {st_idle, st_bus, st_wait_data, st_resp} trk_state_e;

	//////////////////////////////////////////////////
	// byte lane rules
	//////////////////////////////////////////////////

	// one-hot byte, low or high pair for half, all four for word
	function automatic logic [strb_w-1:0] make_strb(mem_size_e size, logic [1:0] off);
		logic [strb_w-1:0] strb;
		case (size)
			size_byte: strb = strb_w'(1) << off;
			size_half: strb = off[1] ? 4'b1100 : 4'b0011;
			default: strb = '1;
		endcase
		return strb;
	endfunction

	// shift the addressed bytes down, then zero-extend
	function automatic logic [data_w-1:0] extract_load(logic [data_w-1:0] word,
		mem_size_e size, logic [1:0] off);
		logic [data_w-1:0] shifted;
		logic [data_w-1:0] res;
		shifted = word >> {off, 3'b000};
		case (size)
			size_byte: res = {{(data_w-8){1'b0}}, shifted[7:0]};
			size_half: res = {{(data_w-16){1'b0}}, shifted[15:0]};
			default: res = shifted;
		endcase
		return res;
	endfunction

endpackage

// ==== src/mbu_if.sv ====
`timescale 1ns/100ps

// decoded request, decode stage to tracker
interface lane_req_if;
	import mbu_pkg::*;

	logic valid;
	logic ready;
	mem_op_e op;
	mem_size_e size;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] wdata;
	logic [strb_w-1:0] strb;
	logic fwd;
	logic [data_w-1:0] fwd_data;

	modport dec (output valid, op, size, addr, wdata, strb, fwd, fwd_data, input ready);
	modport trk (input valid, op, size, addr, wdata, strb, fwd, fwd_data, output ready);
endinterface

// tracker to arbiter, fields held while req is high
interface lane_bus_if;
	import mbu_pkg::*;

	logic req;
	mem_op_e op;
	logic [addr_w-1:0] addr;
	logic [data_w-1:0] wdata;
	logic [strb_w-1:0] strb;
	logic grant;
	logic rvalid;
	logic [data_w-1:0] rdata;

	modport trk (output req, op, addr, wdata, strb, input grant, rvalid, rdata);
	modport arb (input req, op, addr, wdata, strb, output grant, rvalid, rdata);
endinterface

// ==== src/mem_req_decode.sv ====
`timescale 1ns/100ps

module mem_req_decode #(
	parameter int NUM_LANES = mbu_pkg::num_lanes_default
) (
	input logic in_valid [NUM_LANES],
	input mbu_pkg::mem_op_e in_op [NUM_LANES],
	input mbu_pkg::mem_size_e in_size [NUM_LANES],
	input logic [mbu_pkg::addr_w-1:0] in_addr [NUM_LANES],
	input logic [mbu_pkg::data_w-1:0] in_wdata [NUM_LANES],
	output logic in_ready [NUM_LANES],
	lane_req_if.dec req [NUM_LANES]
);
	import mbu_pkg::*;

	logic misaligned [NUM_LANES];

	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_lane
		assign req[i].valid = in_valid[i];
		assign req[i].op = in_op[i];
		assign req[i].size = in_size[i];
		assign req[i].addr = in_addr[i];
		assign req[i].strb = make_strb(in_size[i], in_addr[i][1:0]);
		// store data moves up to its byte lane
		assign req[i].wdata = in_wdata[i] << {in_addr[i][1:0], 3'b000};
		assign in_ready[i] = req[i].ready;

		//////////////////////////////////////////////////
		// same-cycle forwarding, lane 0 store to lane 1 load
		//////////////////////////////////////////////////
		if (i == 1)
		begin : g_fwd
			assign req[i].fwd = in_valid[0] && in_valid[i]
				&& (in_op[0] == op_store) && (in_size[0] == size_word)
				&& (in_op[i] == op_load)
				&& (in_addr[0][addr_w-1:2] == in_addr[i][addr_w-1:2]);
			// word store at offset 0, so no shift needed
			assign req[i].fwd_data = in_wdata[0];
		end
		else
		begin : g_no_fwd
			assign req[i].fwd = 1'b0;
			assign req[i].fwd_data = '0;
		end

		assign misaligned[i] = ((in_size[i] == size_half) && in_addr[i][0])
			|| ((in_size[i] == size_word) && (in_addr[i][1:0] != 2'b00));

		// the strobe rule has no pattern for a straddling access
		always_comb
		begin
			assert final (!(in_valid[i] && misaligned[i]))
				else $error("lane %0d: access not aligned to its size", i);
		end
	end

endmodule

// ==== src/lane_tracker.sv ====
`timescale 1ns/100ps

module lane_tracker #(
	parameter int NUM_LANES = mbu_pkg::num_lanes_default,
	parameter int LANE = 0
) (
	input logic clk,
	input logic arvalid,
	lane_req_if.trk req,
	lane_bus_if.trk bus,
	output logic resp_valid,
	output logic [mbu_pkg::data_w-1:0] resp_data
);
	import mbu_pkg::*;

	trk_state_e state;
	mem_op_e op_q;
	mem_size_e size_q;
	logic [addr_w-1:0] addr_q;
	logic [data_w-1:0] wdata_q;
	logic [strb_w-1:0] strb_q;
	logic [data_w-1:0] load_word_q;
	logic accept;
	logic take_fwd;

	assign accept = req.valid && req.ready;
	// lane 0 has nothing ahead of it to forward from
	assign take_fwd = (LANE != 0) && req.fwd && (req.op == op_load);

	//////////////////////////////////////////////////
	// one outstanding access
	//////////////////////////////////////////////////
	always_ff @(posedge clk or posedge arvalid)
	begin
		if (arvalid)
		begin
			state <= st_idle;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (accept)
						state <= take_fwd ? st_resp : st_bus;
				end
				st_bus:
				begin
					if (bus.grant)
						state <= (op_q == op_store) ? st_resp : st_wait_data;
				end
				st_wait_data:
				begin
					if (bus.rvalid)
						state <= st_resp;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	// access fields and the raw load word
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_q <= req.op;
			size_q <= req.size;
			addr_q <= req.addr;
			wdata_q <= req.wdata;
			strb_q <= req.strb;
		end
		if (accept && take_fwd)
			load_word_q <= req.fwd_data;
		else if ((state == st_wait_data) && bus.rvalid)
			load_word_q <= bus.rdata;
	end

	assign req.ready = (state == st_idle);

	assign bus.req = (state == st_bus);
	assign bus.op = op_q;
	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;
	assign bus.strb = strb_q;

	assign resp_valid = (state == st_resp);
	assign resp_data = (op_q == op_load) ? extract_load(load_word_q, size_q, addr_q[1:0]) : '0;

	// read data routed by id must find this lane waiting
	assert property (@(posedge clk) disable iff (arvalid) bus.rvalid |-> state == st_wait_data)
		else $error("lane %0d of %0d: read data outside wait", LANE, NUM_LANES);

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter #(
	parameter int NUM_LANES = mbu_pkg::num_lanes_default
) (
	input logic clk,
	input logic arvalid,
	output logic [mbu_pkg::addr_w-1:0] rd_addr,
	output logic [mbu_pkg::id_w-1:0] rd_id,
	output logic rd_addr_valid,
	input logic rd_addr_ready,
	input logic [mbu_pkg::data_w-1:0] rd_data,
	input logic [mbu_pkg::id_w-1:0] rd_data_id,
	input logic rd_data_valid,
	output logic [mbu_pkg::addr_w-1:0] wr_addr,
	output logic [mbu_pkg::data_w-1:0] wr_data,
	output logic [mbu_pkg::strb_w-1:0] wr_strb,
	output logic wr_valid,
	input logic wr_ready,
	lane_bus_if.arb bus [NUM_LANES]
);
	import mbu_pkg::*;

	// channel 0 carries loads, channel 1 stores
	localparam int num_ch = 2;
	localparam int ch_rd = 0;
	localparam int ch_wr = 1;

	logic lane_req [NUM_LANES];
	mem_op_e lane_op [NUM_LANES];
	logic [addr_w-1:0] lane_addr [NUM_LANES];
	logic [data_w-1:0] lane_wdata [NUM_LANES];
	logic [strb_w-1:0] lane_strb [NUM_LANES];

	logic ch_busy_q [num_ch];
	logic [id_w-1:0] ch_sel_q [num_ch];
	logic ch_any [num_ch];
	logic [id_w-1:0] ch_pick [num_ch];
	logic [id_w-1:0] ch_cur [num_ch];
	logic ch_valid [num_ch];
	logic ch_ready [num_ch];
	logic ch_fire [num_ch];

	//////////////////////////////////////////////////
	// fixed priority, lowest lane wins
	//////////////////////////////////////////////////
	always_comb
	begin
		mem_op_e want;
		ch_ready[ch_rd] = rd_addr_ready;
		ch_ready[ch_wr] = wr_ready;
		for (int c = 0; c < num_ch; c++)
		begin
			want = (c == ch_rd) ? op_load : op_store;
			ch_any[c] = 1'b0;
			ch_pick[c] = '0;
			for (int i = NUM_LANES - 1; i >= 0; i--)
			begin
				if (lane_req[i] && (lane_op[i] == want))
				begin
					ch_any[c] = 1'b1;
					ch_pick[c] = id_w'(i);
				end
			end
			// a locked lane keeps the channel until its handshake
			ch_cur[c] = ch_busy_q[c] ? ch_sel_q[c] : ch_pick[c];
			ch_valid[c] = ch_busy_q[c] || ch_any[c];
			ch_fire[c] = ch_valid[c] && ch_ready[c];
		end
	end

	always_ff @(posedge clk or posedge arvalid)
	begin
		if (arvalid)
		begin
			for (int c = 0; c < num_ch; c++)
			begin
				ch_busy_q[c] <= 1'b0;
				ch_sel_q[c] <= '0;
			end
		end
		else
		begin
			for (int c = 0; c < num_ch; c++)
			begin
				if (ch_fire[c])
				begin
					ch_busy_q[c] <= 1'b0;
				end
				else if (ch_valid[c])
				begin
					ch_busy_q[c] <= 1'b1;
					ch_sel_q[c] <= ch_cur[c];
				end
			end
		end
	end

	assign rd_addr_valid = ch_valid[ch_rd];
	assign rd_id = ch_cur[ch_rd];
	assign rd_addr = lane_addr[ch_cur[ch_rd]];

	assign wr_valid = ch_valid[ch_wr];
	assign wr_addr = lane_addr[ch_cur[ch_wr]];
	assign wr_data = lane_wdata[ch_cur[ch_wr]];
	assign wr_strb = lane_strb[ch_cur[ch_wr]];

	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_lane
		assign lane_req[i] = bus[i].req;
		assign lane_op[i] = bus[i].op;
		assign lane_addr[i] = bus[i].addr;
		assign lane_wdata[i] = bus[i].wdata;
		assign lane_strb[i] = bus[i].strb;

		assign bus[i].grant = (ch_fire[ch_rd] && (ch_cur[ch_rd] == id_w'(i)))
			|| (ch_fire[ch_wr] && (ch_cur[ch_wr] == id_w'(i)));
		// read data goes back by id
		assign bus[i].rvalid = rd_data_valid && (rd_data_id == id_w'(i));
		assign bus[i].rdata = rd_data;
	end

	assert property (@(posedge clk) disable iff (arvalid)
		rd_addr_valid && !rd_addr_ready |=> rd_addr_valid && $stable(rd_addr) && $stable(rd_id))
		else $error("read address changed while waiting for ready");

endmodule

// ==== src/mem_bus_unit.sv ====
`timescale 1ns/100ps

module mem_bus_unit #(
	parameter int NUM_LANES = mbu_pkg::num_lanes_default
) (
	input logic clk,
	input logic arvalid,
	// lane side
	input logic lane_req_valid [NUM_LANES],
	output logic lane_req_ready [NUM_LANES],
	input mbu_pkg::mem_op_e lane_req_op [NUM_LANES],
	input mbu_pkg::mem_size_e lane_req_size [NUM_LANES],
	input logic [mbu_pkg::addr_w-1:0] lane_req_addr [NUM_LANES],
	input logic [mbu_pkg::data_w-1:0] lane_req_wdata [NUM_LANES],
	output logic lane_resp_valid [NUM_LANES],
	output logic [mbu_pkg::data_w-1:0] lane_resp_data [NUM_LANES],
	// read address channel
	output logic [mbu_pkg::addr_w-1:0] rd_addr,
	output logic [mbu_pkg::id_w-1:0] rd_id,
	output logic rd_addr_valid,
	input logic rd_addr_ready,
	// read data channel, always accepted
	input logic [mbu_pkg::data_w-1:0] rd_data,
	input logic [mbu_pkg::id_w-1:0] rd_data_id,
	input logic rd_data_valid,
	// write channel, address and data together
	output logic [mbu_pkg::addr_w-1:0] wr_addr,
	output logic [mbu_pkg::data_w-1:0] wr_data,
	output logic [mbu_pkg::strb_w-1:0] wr_strb,
	output logic wr_valid,
	input logic wr_ready
);

	lane_req_if req_if [NUM_LANES] ();
	lane_bus_if bus_if [NUM_LANES] ();

	mem_req_decode #(.NUM_LANES(NUM_LANES)) i_mem_req_decode (
		.in_valid(lane_req_valid),
		.in_op(lane_req_op),
		.in_size(lane_req_size),
		.in_addr(lane_req_addr),
		.in_wdata(lane_req_wdata),
		.in_ready(lane_req_ready),
		.req(req_if)
	);

	for (genvar i = 0; i < NUM_LANES; i++)
	begin : g_trk
		lane_tracker #(.NUM_LANES(NUM_LANES), .LANE(i)) i_lane_tracker (
			.clk(clk),
			.arvalid(arvalid),
			.req(req_if[i]),
			.bus(bus_if[i]),
			.resp_valid(lane_resp_valid[i]),
			.resp_data(lane_resp_data[i])
		);
	end

	bus_arbiter #(.NUM_LANES(NUM_LANES)) i_bus_arbiter (
		.clk(clk),
		.arvalid(arvalid),
		.rd_addr(rd_addr),
		.rd_id(rd_id),
		.rd_addr_valid(rd_addr_valid),
		.rd_addr_ready(rd_addr_ready),
		.rd_data(rd_data),
		.rd_data_id(rd_data_id),
		.rd_data_valid(rd_data_valid),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_strb(wr_strb),
		.wr_valid(wr_valid),
		.wr_ready(wr_ready),
		.bus(bus_if)
	);

endmodule

// ==== dv/tb_mem_bus_unit.sv ====
`timescale 1ns/100ps

module tb_mem_bus_unit;
	import mbu_pkg::*;

	localparam int NUM_LANES = num_lanes_default;
	localparam int mem_words = 256;
	// accesses of tests 2 to 6 in order
	localparam int total_acc = 4 + 13 + 16 + 8 + 60;
	localparam int max_lat = 24;
	localparam int timeout_cycles = total_acc * max_lat + 400;

	logic clk = 1'b0;
	logic arvalid;
	logic lane_req_valid [NUM_LANES];
	logic lane_req_ready [NUM_LANES];
	mem_op_e lane_req_op [NUM_LANES];
	mem_size_e lane_req_size [NUM_LANES];
	logic [addr_w-1:0] lane_req_addr [NUM_LANES];
	logic [data_w-1:0] lane_req_wdata [NUM_LANES];
	logic lane_resp_valid [NUM_LANES];
	logic [data_w-1:0] lane_resp_data [NUM_LANES];
	logic [addr_w-1:0] rd_addr;
	logic [id_w-1:0] rd_id;
	logic rd_addr_valid;
	logic rd_addr_ready;
	logic [data_w-1:0] rd_data;
	logic [id_w-1:0] rd_data_id;
	logic rd_data_valid;
	logic [addr_w-1:0] wr_addr;
	logic [data_w-1:0] wr_data;
	logic [strb_w-1:0] wr_strb;
	logic wr_valid;
	logic wr_ready;

	logic [data_w-1:0] mem [mem_words];
	logic [data_w-1:0] shadow [mem_words];
	logic [15:0] lfsr = 16'd47;
	int errors = 0;
	int checks = 0;
	int rd1_count = 0;
	logic stall_en = 1'b0;
	int rd_stretch = 0;
	int wr_stretch = 0;
	logic pend [NUM_LANES];
	int pend_delay [NUM_LANES];
	logic [addr_w-1:0] pend_addr [NUM_LANES];
	logic prev_rd_wait = 1'b0;
	logic prev_wr_wait = 1'b0;
	logic [addr_w-1:0] prev_rd_addr;
	logic [addr_w-1:0] prev_wr_addr;

	// expected responses and store strobes of each lane
	logic exp_is_load_q [NUM_LANES][$];
	logic [data_w-1:0] exp_data_q [NUM_LANES][$];
	logic [addr_w-1:0] st_addr_q [NUM_LANES][$];
	logic [strb_w-1:0] st_strb_q [NUM_LANES][$];

	mem_bus_unit #(.NUM_LANES(NUM_LANES)) i_mem_bus_unit (.*);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////
	// random numbers and reference model
	//////////////////////////////////////////////////
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic int rand_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	function automatic int size_bytes(mem_size_e sz);
		case (sz)
			size_byte: return 1;
			size_half: return 2;
			default: return 4;
		endcase
	endfunction

	function automatic logic [strb_w-1:0] expect_strb(mem_size_e sz, logic [1:0] off);
		logic [strb_w-1:0] s;
		s = '0;
		for (int b = 0; b < size_bytes(sz); b++)
			s[int'(off) + b] = 1'b1;
		return s;
	endfunction

	function automatic logic [data_w-1:0] ref_load(logic [addr_w-1:0] addr, mem_size_e sz);
		logic [data_w-1:0] res;
		logic [data_w-1:0] word;
		res = '0;
		word = shadow[addr[9:2]];
		for (int b = 0; b < size_bytes(sz); b++)
			res[b*8 +: 8] = word[(int'(addr[1:0]) + b)*8 +: 8];
		return res;
	endfunction

	function automatic void ref_store(logic [addr_w-1:0] addr, mem_size_e sz,
		logic [data_w-1:0] wd);
		for (int b = 0; b < size_bytes(sz); b++)
			shadow[addr[9:2]][(int'(addr[1:0]) + b)*8 +: 8] = wd[b*8 +: 8];
	endfunction

	function automatic logic [addr_w-1:0] rand_addr(int base, mem_size_e sz);
		logic [1:0] off;
		if (sz == size_byte)
			off = 2'(rand_bits(2));
		else if (sz == size_half)
			off = {1'(rand_bits(1)), 1'b0};
		else
			off = 2'b00;
		return addr_w'((base + rand_bits(4)) * 4) | addr_w'(off);
	endfunction

	task automatic check_data(string what, logic [data_w-1:0] got, logic [data_w-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_strb(string what, logic [strb_w-1:0] got, logic [strb_w-1:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic flag_failure(string what);
		errors++;
		$display("at %0t: %s", $time, what);
	endtask

	//////////////////////////////////////////////////
	// bus memory model and comparing process
	//////////////////////////////////////////////////
	always @(posedge clk)
	begin
		logic hit;
		if (!arvalid)
		begin
			// a store waiting on the write channel keeps its lane busy
			if (wr_valid)
			begin
				for (int l = 0; l < NUM_LANES; l++)
				begin
					if (st_addr_q[l].size() > 0 && st_addr_q[l][0] == wr_addr
						&& lane_req_ready[l])
						flag_failure("a lane took new requests while its write waited");
				end
			end
			if (wr_valid && wr_ready)
			begin
				hit = 1'b0;
				for (int l = 0; l < NUM_LANES; l++)
				begin
					if (!hit && st_addr_q[l].size() > 0 && st_addr_q[l][0] == wr_addr)
					begin
						hit = 1'b1;
						check_strb("wr_strb", wr_strb, st_strb_q[l][0]);
						void'(st_addr_q[l].pop_front());
						void'(st_strb_q[l].pop_front());
					end
				end
				if (!hit)
					flag_failure("a write arrived that no lane issued");
				for (int b = 0; b < strb_w; b++)
					if (wr_strb[b])
						mem[wr_addr[9:2]][b*8 +: 8] = wr_data[b*8 +: 8];
			end
			if (rd_addr_valid && rd_addr_ready)
			begin
				pend[rd_id] = 1'b1;
				pend_addr[rd_id] = rd_addr;
				pend_delay[rd_id] = rand_bits(3);
			end
			if (rd_addr_valid && rd_id == 1)
				rd1_count++;
			if (prev_rd_wait && (!rd_addr_valid || rd_addr != prev_rd_addr))
				flag_failure("read address changed while it waited for ready");
			if (prev_wr_wait && (!wr_valid || wr_addr != prev_wr_addr))
				flag_failure("write address changed while it waited for ready");
			if (rd_addr_valid && lane_req_ready[rd_id])
				flag_failure("a lane took new requests while its read waited");
			prev_rd_wait = rd_addr_valid && !rd_addr_ready;
			prev_wr_wait = wr_valid && !wr_ready;
			prev_rd_addr = rd_addr;
			prev_wr_addr = wr_addr;
			for (int l = 0; l < NUM_LANES; l++)
			begin
				if (lane_resp_valid[l])
				begin
					if (exp_is_load_q[l].size() == 0)
						flag_failure($sformatf("lane %0d responded with nothing outstanding", l));
					else
					begin
						if (exp_is_load_q[l][0])
							check_data($sformatf("lane %0d load", l), lane_resp_data[l],
								exp_data_q[l][0]);
						void'(exp_is_load_q[l].pop_front());
						void'(exp_data_q[l].pop_front());
					end
				end
			end
		end
	end

	// read data returns after its delay in random lane order
	always @(negedge clk)
	begin
		int first;
		logic sent;
		first = int'(lfsr_bit());
		sent = 1'b0;
		rd_data_valid = 1'b0;
		for (int k = 0; k < NUM_LANES; k++)
		begin
			if (!sent && pend[first ^ k] && pend_delay[first ^ k] == 0)
			begin
				sent = 1'b1;
				pend[first ^ k] = 1'b0;
				rd_data_valid = 1'b1;
				rd_data_id = id_w'(first ^ k);
				rd_data = mem[pend_addr[first ^ k][9:2]];
			end
		end
		for (int l = 0; l < NUM_LANES; l++)
			if (pend[l] && pend_delay[l] > 0)
				pend_delay[l]--;
		if (!stall_en)
		begin
			rd_addr_ready = 1'b1;
			wr_ready = 1'b1;
		end
		else
		begin
			if (rd_stretch == 0)
			begin
				rd_addr_ready = lfsr_bit();
				rd_stretch = rand_bits(3);
			end
			else
				rd_stretch--;
			if (wr_stretch == 0)
			begin
				wr_ready = lfsr_bit();
				wr_stretch = rand_bits(3);
			end
			else
				wr_stretch--;
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////
	task automatic present(int l, mem_op_e op, mem_size_e sz, logic [addr_w-1:0] addr,
		logic [data_w-1:0] wd);
		lane_req_valid[l] = 1'b1;
		lane_req_op[l] = op;
		lane_req_size[l] = sz;
		lane_req_addr[l] = addr;
		lane_req_wdata[l] = wd;
		exp_is_load_q[l].push_back(op == op_load);
		if (op == op_store)
		begin
			ref_store(addr, sz, wd);
			exp_data_q[l].push_back('0);
			st_addr_q[l].push_back(addr);
			st_strb_q[l].push_back(expect_strb(sz, addr[1:0]));
		end
		else
			exp_data_q[l].push_back(ref_load(addr, sz));
	endtask

	task automatic accept_all();
		logic busy;
		logic done [NUM_LANES];
		busy = 1'b1;
		while (busy)
		begin
			@(posedge clk);
			for (int l = 0; l < NUM_LANES; l++)
				done[l] = lane_req_valid[l] && lane_req_ready[l];
			@(negedge clk);
			busy = 1'b0;
			for (int l = 0; l < NUM_LANES; l++)
			begin
				if (done[l])
					lane_req_valid[l] = 1'b0;
				busy = busy || lane_req_valid[l];
			end
		end
	endtask

	task automatic drain();
		while (exp_is_load_q[0].size() > 0 || exp_is_load_q[1].size() > 0)
			@(posedge clk);
		@(negedge clk);
	endtask

	task automatic report(string name, int err_before);
		$display("%s: %s", name, (errors == err_before) ? "passed" : "failed");
	endtask

	initial
	begin
		int e;
		logic [addr_w-1:0] a;
		mem_size_e sz;
		arvalid = 1'b1;
		rd_addr_ready = 1'b1;
		wr_ready = 1'b1;
		rd_data = '0;
		rd_data_id = '0;
		rd_data_valid = 1'b0;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			lane_req_valid[l] = 1'b0;
			lane_req_op[l] = op_load;
			lane_req_size[l] = size_word;
			lane_req_addr[l] = '0;
			lane_req_wdata[l] = '0;
			pend[l] = 1'b0;
			pend_delay[l] = 0;
		end
		// fill depends on every address bit
		for (int i = 0; i < mem_words; i++)
		begin
			mem[i] = 32'h9e3779b1 * (i + 1) ^ (i << 20);
			shadow[i] = mem[i];
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		arvalid = 1'b0;

		e = errors;
		if (rd_addr_valid || wr_valid || lane_resp_valid[0] || lane_resp_valid[1])
			flag_failure("a valid output was high after reset");
		if (!lane_req_ready[0] || !lane_req_ready[1])
			flag_failure("a lane was not ready after reset");
		report("test 1 reset state", e);

		e = errors;
		for (int l = 0; l < NUM_LANES; l++)
		begin
			a = rand_addr(l * 32, size_word);
			present(l, op_store, size_word, a, 32'(rand_bits(16) << 16 | rand_bits(16)));
			accept_all();
			present(l, op_load, size_word, a, '0);
			accept_all();
			drain();
		end
		report("test 2 word store and load", e);

		e = errors;
		for (int o = 0; o < 4; o++)
		begin
			present(o % 2, op_store, size_byte, 32'h40 + o, 32'(rand_bits(8)));
			accept_all();
		end
		for (int o = 0; o < 4; o += 2)
		begin
			present(o / 2, op_store, size_half, 32'h44 + o, 32'(rand_bits(16)));
			accept_all();
		end
		drain();
		for (int o = 0; o < 4; o++)
		begin
			present(o % 2, op_load, size_byte, 32'h44 + o, '0);
			accept_all();
		end
		present(0, op_load, size_half, 32'h40, '0);
		present(1, op_load, size_half, 32'h42, '0);
		accept_all();
		present(0, op_load, size_word, 32'h40, '0);
		accept_all();
		drain();
		report("test 3 strobes and merged loads", e);

		e = errors;
		for (int i = 0; i < 8; i++)
		begin
			present(0, op_load, size_word, rand_addr(0, size_word), '0);
			present(1, op_load, size_word, rand_addr(32, size_word), '0);
			accept_all();
			drain();
		end
		report("test 4 parallel loads", e);

		e = errors;
		for (int i = 0; i < 4; i++)
		begin
			sz = mem_size_e'(rand_bits(2) % 3);
			a = rand_addr(64, sz);
			rd1_count = 0;
			present(0, op_store, size_word, {a[addr_w-1:2], 2'b00}, 32'(rand_bits(16) << 16 | i));
			present(1, op_load, sz, a, '0);
			accept_all();
			drain();
			if (rd1_count != 0)
				flag_failure("the forwarded load went out on the read bus");
		end
		report("test 5 store to load forwarding", e);

		e = errors;
		stall_en = 1'b1;
		for (int i = 0; i < 30; i++)
		begin
			for (int l = 0; l < NUM_LANES; l++)
			begin
				sz = mem_size_e'(rand_bits(2) % 3);
				present(l, lfsr_bit() ? op_store : op_load, sz, rand_addr(96 + l * 32, sz),
					32'(rand_bits(16) << 16 | rand_bits(16)));
			end
			accept_all();
		end
		drain();
		stall_en = 1'b0;
		report("test 6 back-pressure", e);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		#(timeout_cycles * 4);
		$display("watchdog expired before the tests completed");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== compile.f ====
src/mbu_pkg.sv
src/mbu_if.sv
src/mem_req_decode.sv
src/lane_tracker.sv
src/bus_arbiter.sv
src/mem_bus_unit.sv
dv/tb_mem_bus_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_mem_bus_unit
BUILD_DIR ?= obj_dir
FILELIST ?= compile.f
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD_DIR)
